// File: pixel_tick.sv
`timescale 1ns/1ps
`default_nettype none

// pixel rate enable derived from the system clock
// pix_en is high for exactly one clk cycle out of every CLK_DIV
module pixel_tick #(
	parameter int CLK_DIV = 4
) (
	input  wire  clk,
	input  wire  rst,
	output logic pix_en
);

	// a one bit counter still exists when no division is asked for
	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [CNT_W-1:0] cnt;

	// the counter runs down and reloads at CLK_DIV-1 after reaching zero
	// the enable is registered so it comes out clean of the compare logic
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt    <= CNT_W'(CLK_DIV - 1);
			pix_en <= 1'b0;
		end else if (cnt == '0) begin
			cnt    <= CNT_W'(CLK_DIV - 1);
			pix_en <= 1'b1;
		end else begin
			cnt    <= cnt - 1'b1;
			pix_en <= 1'b0;
		end
	end

	// with any real division the enable must drop again on the next cycle
	// so downstream logic never sees a stretched pixel
	generate
		if (CLK_DIV > 1) begin : g_single_pulse
			a_single_pulse: assert property (@(posedge clk) disable iff (rst)
				pix_en |=> !pix_en);
		end
	endgenerate

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the VGA testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_vga_top -f vga.f -o tb_vga_top
if [ $? -ne 0 ]; then
	echo "verilator compile step returned an error"
	exit 1
fi

./obj_dir/tb_vga_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the verdict comes from the log text
if grep -q "tests failed" "$LOG"; then
	exit 1
fi
exit 0

// File: tb_vga_ref.svh
`ifndef TB_VGA_REF_SVH
`define TB_VGA_REF_SVH

// expected sync level on one axis for a position on that axis
// the pulse is active low and sits right after the front porch
function automatic logic ref_sync(int pos, int active, int front, int sync);
	return !((pos >= active + front) && (pos < active + front + sync));
endfunction

// expected display enable for a raster position
function automatic logic ref_de(int col, int row, int h_active, int v_active);
	return (col < h_active) && (row < v_active);
endfunction

// expected colour for a raster position under a given mode
// anything outside the active area is black
function automatic rgb_t ref_rgb(int col, int row, pattern_mode_t mode,
		int h_active, int v_active);
	int   bar;
	logic [3:0] level;
	rgb_t bars [8];
	bars  = '{rgb_t'(12'hFFF), rgb_t'(12'hFF0), rgb_t'(12'h0FF), rgb_t'(12'h0F0),
		rgb_t'(12'hF0F), rgb_t'(12'hF00), rgb_t'(12'h00F), rgb_t'(12'h000)};
	bar   = col / (h_active / 8);
	level = 4'((col >> 5) & 15);
	if (!ref_de(col, row, h_active, v_active)) begin
		return '0;
	end
	case (mode)
		PAT_BARS: return bars[bar & 7];
		PAT_GRID: return ((col % 32 == 0) || (row % 32 == 0)) ? rgb_t'(12'hFFF) : '0;
		PAT_RAMP: return '{r: level, g: level, b: level};
		default:  return rgb_t'(12'h888);
	endcase
endfunction

`endif

// File: tb_vga_top.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the VGA subsystem on a reduced raster
// a strobe counting model derives the raster position and compares every pixel
module tb_vga_top import vga_pkg::*; ();

	localparam int H_ACTIVE = 64;
	localparam int H_FRONT  = 4;
	localparam int H_SYNC   = 8;
	localparam int H_BACK   = 4;
	localparam int V_ACTIVE = 32;
	localparam int V_FRONT  = 2;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 4;
	localparam int CLK_DIV  = 4;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// about eleven frames are run in all, two more are allowed as margin
	localparam int FRAMES_RUN = 12;
	localparam int TIMEOUT_NS = (FRAMES_RUN + 2) * H_TOTAL * V_TOTAL * CLK_DIV * 20;

	`include "tb_vga_ref.svh"

	logic          clk = 1'b0;
	logic          rst;
	pattern_mode_t mode;
	logic          hsync;
	logic          vsync;
	logic          de;
	logic          pix_stb;
	rgb_t          rgb;

	// model state, owned by the checker process
	int            k;
	int            col;
	int            row;
	int            gap;
	int            frame_count;
	logic          seen_stb;
	pattern_mode_t model_mode;

	// bookkeeping per test and for the whole run
	string         test_name;
	int            test_checks;
	int            test_errors;
	int            total_tests;
	int            tests_ok;
	int            total_checks;
	int            total_errors;

	vga_top #(
		.CLK_DIV  (CLK_DIV),
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) DUT (
		.clk     (clk),
		.rst     (rst),
		.mode    (mode),
		.hsync   (hsync),
		.vsync   (vsync),
		.de      (de),
		.pix_stb (pix_stb),
		.rgb     (rgb)
	);

	always #10 clk = ~clk;

	task automatic check_sync(input logic exp_h, input logic exp_v,
			input logic act_h, input logic act_v);
		test_checks++;
		if (act_h !== exp_h || act_v !== exp_v) begin
			test_errors++;
			$display("CHECK FAILED %s sync at col %0d row %0d expected h%b v%b actual h%b v%b",
				test_name, col, row, exp_h, exp_v, act_h, act_v);
		end
	endtask

	task automatic check_de(input logic exp_de, input logic act_de);
		test_checks++;
		if (act_de !== exp_de) begin
			test_errors++;
			$display("CHECK FAILED %s de at col %0d row %0d expected %b actual %b",
				test_name, col, row, exp_de, act_de);
		end
	endtask

	task automatic check_rgb(input rgb_t exp_rgb, input rgb_t act_rgb);
		test_checks++;
		if (act_rgb !== exp_rgb) begin
			test_errors++;
			$display("CHECK FAILED %s rgb at col %0d row %0d expected %h actual %h",
				test_name, col, row, exp_rgb, act_rgb);
		end
	endtask

	task automatic check_gap(input int exp_gap, input int act_gap);
		test_checks++;
		if (act_gap != exp_gap) begin
			test_errors++;
			$display("CHECK FAILED %s strobe spacing expected %0d actual %0d",
				test_name, exp_gap, act_gap);
		end
	endtask

	// outputs that a freshly reset DUT must show
	task automatic check_idle();
		check_sync(1'b1, 1'b1, hsync, vsync);
		check_de(1'b0, de);
		check_rgb('0, rgb);
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic finish_test();
		total_tests++;
		total_checks += test_checks;
		total_errors += test_errors;
		if (test_errors == 0) begin
			tests_ok++;
		end
		$display("test %-16s %0d checks %0d errors %s", test_name, test_checks,
			test_errors, (test_errors == 0) ? "ok" : "BAD");
	endtask

	// drives the mode for the next frame halfway down the current one
	// and returns once the last pixel of the current frame was checked
	task automatic run_frame(input pattern_mode_t next_mode);
		int start;
		start = frame_count;
		wait (row == V_TOTAL / 2);
		@(posedge clk);
		mode <= next_mode;
		wait (frame_count > start);
	endtask

	// outputs are sampled on the falling edge, half a clock after they load
	always @(negedge clk) begin
		if (rst) begin
			k          = 0;
			col        = 0;
			row        = 0;
			gap        = 0;
			seen_stb   = 1'b0;
			model_mode = PAT_BARS;
			check_idle();
		end else if (!pix_stb) begin
			gap++;
			if (!seen_stb) begin
				check_idle();
			end
		end else begin
			if (seen_stb) begin
				check_gap(CLK_DIV, gap);
			end
			gap = 1;
			col = k % H_TOTAL;
			row = (k / H_TOTAL) % V_TOTAL;
			check_sync(ref_sync(col, H_ACTIVE, H_FRONT, H_SYNC),
				ref_sync(row, V_ACTIVE, V_FRONT, V_SYNC), hsync, vsync);
			check_de(ref_de(col, row, H_ACTIVE, V_ACTIVE), de);
			check_rgb(ref_rgb(col, row, model_mode, H_ACTIVE, V_ACTIVE), rgb);
			// the mode held on the last pixel rules the whole next frame
			if (col == H_TOTAL - 1 && row == V_TOTAL - 1) begin
				model_mode = mode;
				frame_count++;
			end
			k++;
			seen_stb = 1'b1;
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
		$display("tests failed");
		$finish;
	end

	initial begin
		pattern_mode_t perm [4];
		pattern_mode_t tmp;
		pattern_mode_t diff;
		int            j;
		rst  = 1'b1;
		mode = PAT_BARS;
		void'($urandom(47541));
		perm[0] = PAT_BARS;
		perm[1] = PAT_GRID;
		perm[2] = PAT_RAMP;
		perm[3] = PAT_SOLID;
		// shuffle so every pattern gets one frame in a random order
		for (int i = 3; i > 0; i--) begin
			j       = int'($urandom % 32'(i + 1));
			tmp     = perm[i];
			perm[i] = perm[j];
			perm[j] = tmp;
		end

		start_test("reset_state");
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		wait (seen_stb);
		finish_test();

		start_test("strobe_spacing");
		run_frame(PAT_BARS);
		finish_test();

		start_test("sync_enable");
		run_frame(PAT_BARS);
		run_frame(perm[0]);
		finish_test();

		start_test("colour_patterns");
		run_frame(perm[1]);
		run_frame(perm[2]);
		run_frame(perm[3]);
		run_frame(perm[3]);
		finish_test();

		// a mode that differs from the one on screen and is never bars
		diff = (perm[3] == PAT_GRID) ? PAT_RAMP : PAT_GRID;
		start_test("frame_latch");
		run_frame(diff);
		run_frame(diff);
		finish_test();

		// the frame after this reset must start at zero and show bars again
		start_test("reset_mid_frame");
		wait (row == V_TOTAL / 2);
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		run_frame(diff);
		finish_test();

		$display("%0d of %0d tests clean, %0d checks, %0d errors", tests_ok, total_tests,
			total_checks, total_errors);
		if (total_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test_pattern.sv
`timescale 1ns/1ps
`default_nettype none

// test pattern generator
// produces the colour of each pixel from the raster position and the
// pattern mode, which only changes between frames
module test_pattern import vga_pkg::*; #(
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int V_ACTIVE = DEF_V_ACTIVE
) (
	input  wire                clk,
	input  wire                rst,
	input  wire                pix_en,
	input  wire                frame_end,
	input  wire  [COORD_W-1:0] x,
	input  wire  [COORD_W-1:0] y,
	input  pattern_mode_t      mode,
	output rgb_t               rgb
);

	// eight bars share the active width equally
	localparam int BAR_W = H_ACTIVE / 8;

	pattern_mode_t      frame_mode;
	logic               active;
	logic [COORD_W-1:0] bar_q;
	logic [2:0]         bar_sel;
	logic               grid_line;
	rgb_t               bar_rgb;
	rgb_t               pix_rgb;

	assign active = (x < H_ACTIVE) && (y < V_ACTIVE);

	// bar number from the column
	// inside the active area the quotient stays below eight
	assign bar_q   = x / COORD_W'(BAR_W);
	assign bar_sel = bar_q[2:0];

	// grid lines every 32 pixels in both directions
	assign grid_line = (x[4:0] == 5'd0) || (y[4:0] == 5'd0);

	// classic colour bar order, each channel fully on or off
	always_comb begin
		case (bar_sel)
			3'd0:    bar_rgb = rgb_t'(12'hFFF);
			3'd1:    bar_rgb = rgb_t'(12'hFF0);
			3'd2:    bar_rgb = rgb_t'(12'h0FF);
			3'd3:    bar_rgb = rgb_t'(12'h0F0);
			3'd4:    bar_rgb = rgb_t'(12'hF0F);
			3'd5:    bar_rgb = rgb_t'(12'hF00);
			3'd6:    bar_rgb = rgb_t'(12'h00F);
			default: bar_rgb = rgb_t'(12'h000);
		endcase
	end

	// colour for the current position under the mode of this frame
	always_comb begin
		case (frame_mode)
			PAT_BARS: pix_rgb = bar_rgb;
			PAT_GRID: pix_rgb = grid_line ? rgb_t'(12'hFFF) : rgb_t'(12'h000);
			// the ramp steps once every 32 columns across the line
			PAT_RAMP: pix_rgb = '{r: x[8:5], g: x[8:5], b: x[8:5]};
			default:  pix_rgb = rgb_t'(12'h888);
		endcase
	end

	// the mode input is sampled on the last pixel of a frame only
	// the colour loaded on that same edge still uses the old mode
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_mode <= PAT_BARS;
		end else if (pix_en && frame_end) begin
			frame_mode <= mode;
		end
	end

	// blanking forces black so the DAC never drives during sync
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= '0;
		end else if (pix_en) begin
			rgb <= active ? pix_rgb : '0;
		end
	end

	// the bar number is cut down to three bits
	// an active width that is not a multiple of eight would wrap the last columns to white
	a_bar_range: assert property (@(posedge clk) disable iff (rst)
		active |-> bar_q < COORD_W'(8));

endmodule

`default_nettype wire

// File: vga.f
+incdir+.
vga_pkg.sv
pixel_tick.sv
vga_timing.sv
test_pattern.sv
vga_top.sv
tb_vga_top.sv

// File: vga_pkg.sv
`default_nettype none

package vga_pkg;

	// width of the column and row counters
	// ten bits reach 1023, which covers the 800 x 525 raster of 640x480
	localparam int COORD_W = 10;

	// test pattern selection
	// the generator only picks up a new value at a frame boundary
	typedef enum logic [1:0] {
		PAT_BARS  = 2'd0,
		PAT_GRID  = 2'd1,
		PAT_RAMP  = 2'd2,
		PAT_SOLID = 2'd3
	} pattern_mode_t;

	// 12-bit colour as it goes to the DAC
	// red sits in the top nibble and blue in the bottom one
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// horizontal timing of 640x480 at 60 Hz, counted in pixel clocks
	localparam int DEF_H_ACTIVE = 640;
	localparam int DEF_H_FRONT  = 16;
	localparam int DEF_H_SYNC   = 96;
	localparam int DEF_H_BACK   = 48;

	// vertical timing of the same mode, counted in lines
	localparam int DEF_V_ACTIVE = 480;
	localparam int DEF_V_FRONT  = 10;
	localparam int DEF_V_SYNC   = 2;
	localparam int DEF_V_BACK   = 33;

	// a 100 MHz system clock divided by four gives the 25 MHz pixel rate
	localparam int DEF_CLK_DIV  = 4;

endpackage

`default_nettype wire

// File: vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

// raster timing generator
// counts columns and rows at the pixel rate and produces registered
// active low sync pulses, the display enable and the pixel strobe
module vga_timing import vga_pkg::*; #(
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int H_FRONT  = DEF_H_FRONT,
	parameter int H_SYNC   = DEF_H_SYNC,
	parameter int H_BACK   = DEF_H_BACK,
	parameter int V_ACTIVE = DEF_V_ACTIVE,
	parameter int V_FRONT  = DEF_V_FRONT,
	parameter int V_SYNC   = DEF_V_SYNC,
	parameter int V_BACK   = DEF_V_BACK
) (
	input  wire                clk,
	input  wire                rst,
	input  wire                pix_en,
	output logic [COORD_W-1:0] x,
	output logic [COORD_W-1:0] y,
	output logic               frame_end,
	output logic               hsync,
	output logic               vsync,
	output logic               de,
	output logic               pix_stb
);

	// full line and frame lengths including blanking
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// the sync pulse starts right after the front porch
	// the end values are exclusive
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int HS_END   = H_ACTIVE + H_FRONT + H_SYNC;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int VS_END   = V_ACTIVE + V_FRONT + V_SYNC;

	logic h_end;
	logic v_end;
	logic h_sync_on;
	logic v_sync_on;
	logic active;

	// last column of a line and last line of a frame
	assign h_end = (x == COORD_W'(H_TOTAL - 1));
	assign v_end = (y == COORD_W'(V_TOTAL - 1));

	// the pattern generator uses this to switch modes between frames
	assign frame_end = h_end && v_end;

	// decode of the current position before the counters move on
	assign h_sync_on = (x >= HS_START) && (x < HS_END);
	assign v_sync_on = (y >= VS_START) && (y < VS_END);
	assign active    = (x < H_ACTIVE) && (y < V_ACTIVE);

	// column and row counters
	// the row only steps when the column wraps
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x <= '0;
			y <= '0;
		end else if (pix_en) begin
			if (h_end) begin
				x <= '0;
				if (v_end) begin
					y <= '0;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// output registers load on the same edge that advances the counters
	// so they show the position the counters held just before it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			de    <= 1'b0;
		end else if (pix_en) begin
			hsync <= !h_sync_on;
			vsync <= !v_sync_on;
			de    <= active;
		end
	end

	// the strobe marks the first cycle in which the new outputs are valid
	// which is one clk after the enable that loaded them
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pix_stb <= 1'b0;
		end else begin
			pix_stb <= pix_en;
		end
	end

	// the counters must never step past the raster
	// a miss here would mean a broken wrap compare
	a_x_range: assert property (@(posedge clk) disable iff (rst)
		x < H_TOTAL);
	a_y_range: assert property (@(posedge clk) disable iff (rst)
		y < V_TOTAL);

endmodule

`default_nettype wire

// File: vga_top.sv
`timescale 1ns/1ps
`default_nettype none

// VGA output subsystem
// pixel enable divider, raster timing and test pattern feeding a DAC
// all timing values come in as parameters and are handed down from here
module vga_top import vga_pkg::*; #(
	parameter int CLK_DIV  = DEF_CLK_DIV,
	parameter int H_ACTIVE = DEF_H_ACTIVE,
	parameter int H_FRONT  = DEF_H_FRONT,
	parameter int H_SYNC   = DEF_H_SYNC,
	parameter int H_BACK   = DEF_H_BACK,
	parameter int V_ACTIVE = DEF_V_ACTIVE,
	parameter int V_FRONT  = DEF_V_FRONT,
	parameter int V_SYNC   = DEF_V_SYNC,
	parameter int V_BACK   = DEF_V_BACK
) (
	input  wire           clk,
	input  wire           rst,
	input  pattern_mode_t mode,
	output logic          hsync,
	output logic          vsync,
	output logic          de,
	output logic          pix_stb,
	output rgb_t          rgb
);

	// one clk wide pulse at the pixel rate
	logic               pix_en;
	// raster position and end of frame from the timing block
	logic [COORD_W-1:0] x;
	logic [COORD_W-1:0] y;
	logic               frame_end;

	pixel_tick #(
		.CLK_DIV (CLK_DIV)
	) u_pixel_tick (
		.clk    (clk),
		.rst    (rst),
		.pix_en (pix_en)
	);

	vga_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) u_vga_timing (
		.clk       (clk),
		.rst       (rst),
		.pix_en    (pix_en),
		.x         (x),
		.y         (y),
		.frame_end (frame_end),
		.hsync     (hsync),
		.vsync     (vsync),
		.de        (de),
		.pix_stb   (pix_stb)
	);

	// the pattern block only needs the active size for bars and bounds
	test_pattern #(
		.H_ACTIVE (H_ACTIVE),
		.V_ACTIVE (V_ACTIVE)
	) u_test_pattern (
		.clk       (clk),
		.rst       (rst),
		.pix_en    (pix_en),
		.frame_end (frame_end),
		.x         (x),
		.y         (y),
		.mode      (mode),
		.rgb       (rgb)
	);

endmodule

`default_nettype wire
